// File: coproc_pkg.sv
`default_nettype none

package coproc_pkg;

  localparam int unsigned xlen     = 32;
  localparam int unsigned id_width = 4;

  localparam logic [xlen-1:0] test_magic = 32'hdead_beef;  // test opcode result

  typedef logic [xlen-1:0]     word_t;     // data or address
  typedef logic [id_width-1:0] id_t;       // offloaded instruction id
  typedef logic [4:0]          reg_idx_t;  // integer register index
  typedef logic [2*xlen-1:0]   dword_t;    // two consecutive words

  // custom opcode space
  typedef enum logic [6:0] {
    opcode_rmld = 7'b000_1011,  // custom-0
    opcode_rmst = 7'b010_1011,  // custom-1
    opcode_test = 7'b101_1011   // custom-2
  } opcode_e;

  // bit 2 set marks a configuration instruction
  typedef enum logic [2:0] {
    rmcs   = 3'd0,  // store shadow
    rmcc   = 3'd1,  // store data register
    rmxr   = 3'd2,  // store zeros
    rmxs   = 3'd3,  // store ones
    cdsrm  = 3'd4,  // data register from rs1
    casrm  = 3'd5,  // store address from rs1
    calrm  = 3'd6,  // load address from rs2
    caslrm = 3'd7   // both addresses
  } funct3_e;

  typedef enum logic [2:0] {
    idle,
    cfg,
    wait_commit,
    mem_rd1,
    mem_rd2,
    mem_wr,
    retire
  } coproc_state_e;

  typedef struct packed {
    word_t instr;
    word_t rs1;
    word_t rs2;
    id_t   id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic loadstore;
  } issue_resp_t;

  typedef struct packed {
    id_t  id;
    logic kill;
  } commit_t;

  typedef struct packed {
    id_t   id;
    word_t addr;
    logic  we;
    word_t wdata;
    logic  last;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
    logic  err;  // not acted on
  } mem_result_t;

  typedef struct packed {
    id_t      id;
    reg_idx_t rd;
    word_t    data;
    logic     we;
  } result_t;

  // instruction held by the issue stage
  typedef struct packed {
    opcode_e  opcode;
    funct3_e  funct3;
    word_t    rs1;
    word_t    rs2;
    reg_idx_t rd;
    id_t      id;
  } insn_t;

endpackage

`default_nettype wire

// File: coproc_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module coproc_issue_stage (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  // issue interface
  input  wire                          issue_valid,
  output logic                         issue_ready,
  input  wire coproc_pkg::issue_req_t  issue_req,
  output coproc_pkg::issue_resp_t      issue_resp,
  // commit interface
  input  wire                          commit_valid,
  input  wire coproc_pkg::commit_t     commit,
  // controller side
  input  wire                          idle,
  input  wire                          insn_done,
  output coproc_pkg::insn_t            insn,
  output logic                         insn_valid,
  output logic                         committed,
  output logic                         killed
);

  coproc_pkg::opcode_e opcode;
  logic                is_rmld;
  logic                is_rmst;
  logic                is_test;
  logic                take;
  logic                commit_hit;

  assign opcode  = coproc_pkg::opcode_e'(issue_req.instr[6:0]);
  assign is_rmld = (opcode == coproc_pkg::opcode_rmld);
  assign is_rmst = (opcode == coproc_pkg::opcode_rmst);
  assign is_test = (opcode == coproc_pkg::opcode_test);

  always_comb begin
    issue_resp.accept    = is_rmld | is_rmst | is_test;
    issue_resp.writeback = is_test;  // only the test opcode writes rd
    // config forms never touch memory
    issue_resp.loadstore = (is_rmld | is_rmst) & ~issue_req.instr[14];
  end

  // a new instruction only once the previous one has fully left
  assign issue_ready = idle & ~insn_valid;
  assign take        = issue_valid & issue_ready & issue_resp.accept;

  // commit may also target the instruction being taken this cycle
  assign commit_hit = commit_valid &&
                      ((insn_valid && (commit.id == insn.id)) ||
                       (take && (commit.id == issue_req.id)));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn <= '0;
    end else if (take) begin
      insn.opcode <= opcode;
      insn.funct3 <= coproc_pkg::funct3_e'(issue_req.instr[14:12]);
      insn.rs1    <= issue_req.rs1;
      insn.rs2    <= issue_req.rs2;
      insn.rd     <= issue_req.instr[11:7];
      insn.id     <= issue_req.id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_valid <= 1'b0;
      committed  <= 1'b0;
      killed     <= 1'b0;
    end else if (insn_done) begin
      insn_valid <= 1'b0;
      committed  <= 1'b0;
      killed     <= 1'b0;
    end else begin
      if (take) begin
        insn_valid <= 1'b1;
      end
      if (commit_hit && !commit.kill) begin
        committed <= 1'b1;  // sticky until done
      end
      if (commit_hit && commit.kill) begin
        killed <= 1'b1;
      end
    end
  end

  // the core resolves each id exactly once
  commit_kill_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(committed && killed));

  issue_req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid && !issue_ready |=> issue_valid && $stable(issue_req));

endmodule

`default_nettype wire

// File: coproc_stream_regs.sv
`timescale 1ns/1ps
`default_nettype none

module coproc_stream_regs (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire coproc_pkg::insn_t   insn,
  // strobes from the controller
  input  wire                      cfg_we,
  input  wire                      rbuf_lo_we,
  input  wire                      rbuf_hi_we,
  input  wire                      shadow_we,
  input  wire coproc_pkg::word_t   rdata,
  output coproc_pkg::word_t        ld_addr,
  output coproc_pkg::word_t        st_addr,
  output coproc_pkg::word_t        store_data
);

  coproc_pkg::word_t  data_q;    // custom data register
  coproc_pkg::word_t  shadow_q;
  coproc_pkg::dword_t rbuf_q;    // first read in the low half

  // configuration
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_addr <= '0;
      st_addr <= '0;
      data_q  <= '0;
    end else if (cfg_we) begin
      case (insn.funct3)
        coproc_pkg::cdsrm: begin
          data_q <= insn.rs1;
        end
        coproc_pkg::casrm: begin
          st_addr <= insn.rs1;
        end
        coproc_pkg::calrm: begin
          ld_addr <= insn.rs2;
        end
        coproc_pkg::caslrm: begin
          st_addr <= insn.rs1;
          ld_addr <= insn.rs2;
        end
        default: begin
        end
      endcase
    end
  end

  // read buffer and shadow
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rbuf_q   <= '0;
      shadow_q <= '0;
    end else begin
      if (rbuf_lo_we) begin
        rbuf_q[31:0] <= rdata;
      end
      if (rbuf_hi_we) begin
        rbuf_q[63:32] <= rdata;
      end
      if (shadow_we) begin
        shadow_q <= rbuf_q[47:16];  // word starting at byte 2
      end
    end
  end

  // store data selection
  always_comb begin
    case (insn.funct3)
      coproc_pkg::rmcs: store_data = shadow_q;
      coproc_pkg::rmcc: store_data = data_q;
      coproc_pkg::rmxr: store_data = '0;
      coproc_pkg::rmxs: store_data = '1;
      default:          store_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: coproc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module coproc_ctrl (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  // issue stage side
  input  wire coproc_pkg::insn_t   insn,
  input  wire                      insn_valid,
  input  wire                      committed,
  input  wire                      killed,
  output logic                     idle,
  output logic                     insn_done,
  // memory request and result
  output logic                     mem_valid,
  input  wire                      mem_ready,
  output coproc_pkg::mem_req_t     mem_req,
  input  wire                      mem_result_valid,
  // stream register strobes
  output logic                     cfg_we,
  output logic                     rbuf_lo_we,
  output logic                     rbuf_hi_we,
  output logic                     shadow_we,
  input  wire coproc_pkg::word_t   ld_addr,
  input  wire coproc_pkg::word_t   st_addr,
  input  wire coproc_pkg::word_t   store_data,
  // result interface
  output logic                     result_valid,
  input  wire                      result_ready,
  output coproc_pkg::result_t      result
);

  coproc_pkg::coproc_state_e state_q;
  coproc_pkg::coproc_state_e state_d;
  logic req_done_q;  // request of this state handshaken
  logic mem_fire;
  logic mem_resp;
  logic is_test;
  logic is_load;
  logic is_cfg;

  assign is_test = (insn.opcode == coproc_pkg::opcode_test);
  assign is_load = (insn.opcode == coproc_pkg::opcode_rmld);
  assign is_cfg  = insn.funct3[2];

  assign idle     = (state_q == coproc_pkg::idle);
  assign mem_valid = (state_q inside {coproc_pkg::mem_rd1, coproc_pkg::mem_rd2,
                                      coproc_pkg::mem_wr}) && !req_done_q;
  assign mem_fire = mem_valid & mem_ready;
  assign mem_resp = req_done_q & mem_result_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= coproc_pkg::idle;
      req_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d != state_q) begin
        req_done_q <= 1'b0;  // one request per state
      end else if (mem_fire) begin
        req_done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    state_d    = state_q;
    insn_done  = 1'b0;
    cfg_we     = 1'b0;
    rbuf_lo_we = 1'b0;
    rbuf_hi_we = 1'b0;
    shadow_we  = 1'b0;
    case (state_q)
      coproc_pkg::idle: begin
        if (insn_valid) begin
          if (killed) begin
            insn_done = 1'b1;
          end else if (is_test) begin
            state_d = coproc_pkg::wait_commit;
          end else if (is_cfg) begin
            state_d = coproc_pkg::cfg;
          end else begin
            state_d = coproc_pkg::mem_rd1;
          end
        end
      end
      coproc_pkg::cfg: begin
        if (killed) begin
          insn_done = 1'b1;
          state_d   = coproc_pkg::idle;
        end else if (committed) begin
          cfg_we  = 1'b1;
          state_d = coproc_pkg::retire;
        end
      end
      // a killed read still drains its result, which is dropped
      coproc_pkg::mem_rd1: begin
        if (mem_resp) begin
          if (killed) begin
            insn_done = 1'b1;
            state_d   = coproc_pkg::idle;
          end else begin
            rbuf_lo_we = 1'b1;
            state_d    = coproc_pkg::mem_rd2;
          end
        end
      end
      coproc_pkg::mem_rd2: begin
        if (mem_resp) begin
          if (killed) begin
            insn_done = 1'b1;
            state_d   = coproc_pkg::idle;
          end else begin
            rbuf_hi_we = 1'b1;
            state_d    = coproc_pkg::wait_commit;
          end
        end
      end
      coproc_pkg::wait_commit: begin
        if (killed) begin
          insn_done = 1'b1;
          state_d   = coproc_pkg::idle;
        end else if (committed) begin
          if (is_test) begin
            state_d = coproc_pkg::retire;
          end else begin
            shadow_we = 1'b1;
            state_d   = is_load ? coproc_pkg::retire : coproc_pkg::mem_wr;
          end
        end
      end
      coproc_pkg::mem_wr: begin
        if (mem_resp) begin
          state_d = coproc_pkg::retire;  // committed, kill no longer applies
        end
      end
      coproc_pkg::retire: begin
        if (result_ready) begin
          insn_done = 1'b1;
          state_d   = coproc_pkg::idle;
        end
      end
      default: begin
        state_d = coproc_pkg::idle;
      end
    endcase
  end

  always_comb begin
    mem_req.id    = insn.id;
    mem_req.we    = (state_q == coproc_pkg::mem_wr);
    mem_req.wdata = mem_req.we ? store_data : '0;
    // final access of the instruction
    mem_req.last  = mem_req.we || ((state_q == coproc_pkg::mem_rd2) && is_load);
    case (state_q)
      coproc_pkg::mem_rd2: mem_req.addr = ld_addr + coproc_pkg::word_t'(4);
      coproc_pkg::mem_wr:  mem_req.addr = st_addr;
      default:             mem_req.addr = ld_addr;
    endcase
  end

  assign result_valid = (state_q == coproc_pkg::retire);

  always_comb begin
    result.id   = insn.id;
    result.rd   = insn.rd;
    result.data = is_test ? coproc_pkg::test_magic : '0;
    result.we   = is_test;
  end

  mem_req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_req));

  result_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid && !result_ready |=> result_valid && $stable(result));

  // memory answers only a handshaken request, never a second one
  mem_result_outst_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_result_valid |-> req_done_q);

endmodule

`default_nettype wire

// File: coproc_top.sv
`timescale 1ns/1ps
`default_nettype none

module coproc_top (
  input  wire                            clk_i,
  input  wire                            rst_ni,
  // issue
  input  wire                            issue_valid,
  output logic                           issue_ready,
  input  wire coproc_pkg::issue_req_t    issue_req,
  output coproc_pkg::issue_resp_t        issue_resp,
  // commit
  input  wire                            commit_valid,
  input  wire coproc_pkg::commit_t       commit,
  // memory request
  output logic                           mem_valid,
  input  wire                            mem_ready,
  output coproc_pkg::mem_req_t           mem_req,
  // memory result
  input  wire                            mem_result_valid,
  input  wire coproc_pkg::mem_result_t   mem_result,
  // result
  output logic                           result_valid,
  input  wire                            result_ready,
  output coproc_pkg::result_t            result
);

  coproc_pkg::insn_t insn;
  logic              insn_valid;
  logic              committed;
  logic              killed;
  logic              idle;
  logic              insn_done;
  logic              cfg_we;
  logic              rbuf_lo_we;
  logic              rbuf_hi_we;
  logic              shadow_we;
  coproc_pkg::word_t ld_addr;
  coproc_pkg::word_t st_addr;
  coproc_pkg::word_t store_data;

  coproc_issue_stage u_issue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue_req    (issue_req),
    .issue_resp   (issue_resp),
    .commit_valid (commit_valid),
    .commit       (commit),
    .idle         (idle),
    .insn_done    (insn_done),
    .insn         (insn),
    .insn_valid   (insn_valid),
    .committed    (committed),
    .killed       (killed)
  );

  coproc_stream_regs u_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .insn       (insn),
    .cfg_we     (cfg_we),
    .rbuf_lo_we (rbuf_lo_we),
    .rbuf_hi_we (rbuf_hi_we),
    .shadow_we  (shadow_we),
    .rdata      (mem_result.rdata),
    .ld_addr    (ld_addr),
    .st_addr    (st_addr),
    .store_data (store_data)
  );

  coproc_ctrl u_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .insn             (insn),
    .insn_valid       (insn_valid),
    .committed        (committed),
    .killed           (killed),
    .idle             (idle),
    .insn_done        (insn_done),
    .mem_valid        (mem_valid),
    .mem_ready        (mem_ready),
    .mem_req          (mem_req),
    .mem_result_valid (mem_result_valid),
    .cfg_we           (cfg_we),
    .rbuf_lo_we       (rbuf_lo_we),
    .rbuf_hi_we       (rbuf_hi_we),
    .shadow_we        (shadow_we),
    .ld_addr          (ld_addr),
    .st_addr          (st_addr),
    .store_data       (store_data),
    .result_valid     (result_valid),
    .result_ready     (result_ready),
    .result           (result)
  );

endmodule

`default_nettype wire

// File: coproc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module coproc_tb;

  localparam int num_tests  = 6;
  localparam int max_cycles = num_tests * 200;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    issue_valid;
  logic                    issue_ready;
  coproc_pkg::issue_req_t  issue_req;
  coproc_pkg::issue_resp_t issue_resp;
  logic                    commit_valid;
  coproc_pkg::commit_t     commit;
  logic                    mem_valid;
  logic                    mem_ready;
  coproc_pkg::mem_req_t    mem_req;
  logic                    mem_result_valid;
  coproc_pkg::mem_result_t mem_result;
  logic                    result_valid;
  logic                    result_ready;
  coproc_pkg::result_t     result;

  coproc_pkg::word_t   mem [0:255];  // word addressed, 1 KiB
  coproc_pkg::word_t   wr_addr_q[$];
  coproc_pkg::word_t   wr_data_q[$];
  logic                wr_last_q[$];
  coproc_pkg::id_t     wr_id_q[$];
  coproc_pkg::result_t res_q[$];
  integer              seed;
  logic                bp_on;  // random stalls on mem_ready and result_ready
  int                  errors;
  int                  errors_at_start;
  int                  failing;
  int                  tests_run;
  int                  cycles = 0;
  string               cur_test;
  coproc_pkg::id_t     next_id;

  coproc_top dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .issue_valid      (issue_valid),
    .issue_ready      (issue_ready),
    .issue_req        (issue_req),
    .issue_resp       (issue_resp),
    .commit_valid     (commit_valid),
    .commit           (commit),
    .mem_valid        (mem_valid),
    .mem_ready        (mem_ready),
    .mem_req          (mem_req),
    .mem_result_valid (mem_result_valid),
    .mem_result       (mem_result),
    .result_valid     (result_valid),
    .result_ready     (result_ready),
    .result           (result)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("test failed");
      $finish;
    end
  end

  // memory with 1 to 3 cycles of response latency
  initial begin : mem_model
    int                delay;
    int                i;
    logic              pending;
    coproc_pkg::word_t rdata;
    pending          = 1'b0;
    delay            = 0;
    rdata            = '0;
    mem_ready        = 1'b0;
    mem_result_valid = 1'b0;
    mem_result       = '0;
    for (i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'd1};  // distinct bytes
    end
    forever begin
      @(negedge clk_i);
      mem_result_valid = 1'b0;
      if (pending) begin
        if (delay == 0) begin
          mem_result_valid = 1'b1;
          mem_result.rdata = rdata;
          pending          = 1'b0;
        end else begin
          delay--;
        end
      end
      mem_ready = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
      if (mem_valid && mem_ready) begin  // handshake on the coming edge
        if (mem_req.we) begin
          wr_addr_q.push_back(mem_req.addr);
          wr_data_q.push_back(mem_req.wdata);
          wr_last_q.push_back(mem_req.last);
          wr_id_q.push_back(mem_req.id);
          mem[mem_req.addr[9:2]] = mem_req.wdata;
          rdata = '0;
        end else begin
          rdata = mem[mem_req.addr[9:2]];
        end
        pending = 1'b1;
        delay   = $unsigned($random(seed)) % 3;
      end
    end
  end

  initial begin : result_sink
    result_ready = 1'b0;
    forever begin
      @(negedge clk_i);
      result_ready = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
      if (result_valid && result_ready) begin
        res_q.push_back(result);
      end
    end
  end

  task automatic check_word(input string what, input coproc_pkg::word_t exp,
                            input coproc_pkg::word_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_id(input string what, input coproc_pkg::id_t exp,
                          input coproc_pkg::id_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bool(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("error %s: %s expected %b actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic flag_failure(input string msg);
    errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  function automatic coproc_pkg::word_t encode(input coproc_pkg::opcode_e op,
                                               input coproc_pkg::funct3_e f3,
                                               input coproc_pkg::reg_idx_t rd);
    return {17'd0, f3, rd, op};
  endfunction

  // little-endian bytes 2 to 5 from addr
  function automatic coproc_pkg::word_t window_word(input coproc_pkg::word_t addr);
    coproc_pkg::word_t lo;
    coproc_pkg::word_t hi;
    lo = mem[addr[9:2]];
    hi = mem[addr[9:2] + 8'd1];
    return {hi[15:0], lo[31:16]};
  endfunction

  task automatic issue_insn(input coproc_pkg::word_t instr, input coproc_pkg::word_t rs1,
                            input coproc_pkg::word_t rs2, input coproc_pkg::id_t id,
                            output coproc_pkg::issue_resp_t resp);
    logic taken;
    taken = 1'b0;
    @(negedge clk_i);
    issue_valid = 1'b1;
    issue_req   = '{instr: instr, rs1: rs1, rs2: rs2, id: id};
    while (!taken) begin
      #1;
      taken = issue_ready && issue_resp.accept;
      resp  = issue_resp;
      @(negedge clk_i);
    end
    issue_valid = 1'b0;
  endtask

  task automatic send_commit(input coproc_pkg::id_t id, input logic kill);
    commit_valid = 1'b1;
    commit       = '{id: id, kill: kill};
    @(negedge clk_i);
    commit_valid = 1'b0;
  endtask

  task automatic take_result(output coproc_pkg::result_t r);
    while (res_q.size() == 0) begin
      @(negedge clk_i);
    end
    r = res_q.pop_front();
  endtask

  task automatic wait_idle();
    while (!issue_ready) begin
      @(negedge clk_i);
    end
  endtask

  // config, load or store that commits and returns no register value
  task automatic exec_insn(input coproc_pkg::opcode_e op, input coproc_pkg::funct3_e f3,
                           input coproc_pkg::word_t rs1, input coproc_pkg::word_t rs2);
    coproc_pkg::issue_resp_t resp;
    coproc_pkg::result_t     r;
    coproc_pkg::id_t         id;
    id = next_id;
    next_id++;
    issue_insn(encode(op, f3, 5'd9), rs1, rs2, id, resp);
    check_bool("writeback", 1'b0, resp.writeback);
    check_bool("loadstore", !f3[2], resp.loadstore);
    send_commit(id, 1'b0);
    take_result(r);
    check_id("result id", id, r.id);
    check_bool("result we", 1'b0, r.we);
  endtask

  task automatic store_check(input coproc_pkg::funct3_e f3, input coproc_pkg::word_t addr,
                             input coproc_pkg::word_t data);
    coproc_pkg::id_t id;
    id = next_id;  // id that the store is issued with
    exec_insn(coproc_pkg::opcode_rmst, f3, '0, '0);
    if (wr_addr_q.size() != 1) begin
      flag_failure($sformatf("expected one memory write, saw %0d", wr_addr_q.size()));
    end else begin
      check_word("write address", addr, wr_addr_q.pop_front());
      check_word("write data", data, wr_data_q.pop_front());
      check_bool("write last", 1'b1, wr_last_q.pop_front());
      check_id("write id", id, wr_id_q.pop_front());
    end
    wr_addr_q.delete();
    wr_data_q.delete();
    wr_last_q.delete();
    wr_id_q.delete();
  endtask

  task automatic run_config_load();
    exec_insn(coproc_pkg::opcode_rmld, coproc_pkg::caslrm, 32'h200, 32'h40);
    exec_insn(coproc_pkg::opcode_rmld, coproc_pkg::rmcs, '0, '0);
    if (wr_addr_q.size() != 0) begin
      flag_failure("load wrote to memory");
    end
    store_check(coproc_pkg::rmcs, 32'h200, window_word(32'h40));
  endtask

  task automatic run_store_selects();
    exec_insn(coproc_pkg::opcode_rmst, coproc_pkg::caslrm, 32'h200, 32'h40);
    exec_insn(coproc_pkg::opcode_rmst, coproc_pkg::cdsrm, 32'h1234_5678, 32'h0);
    store_check(coproc_pkg::rmcc, 32'h200, 32'h1234_5678);
    store_check(coproc_pkg::rmxr, 32'h200, 32'h0);
    store_check(coproc_pkg::rmxs, 32'h200, 32'hffff_ffff);
    exec_insn(coproc_pkg::opcode_rmst, coproc_pkg::casrm, 32'h300, 32'h3c0);  // ld unchanged
    store_check(coproc_pkg::rmcs, 32'h300, window_word(32'h40));
    exec_insn(coproc_pkg::opcode_rmst, coproc_pkg::calrm, 32'h3f0, 32'h80);   // st unchanged
    store_check(coproc_pkg::rmcs, 32'h300, window_word(32'h80));
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    int n;
    n = errors - errors_at_start;
    tests_run++;
    if (n != 0) begin
      failing++;
    end
    $display("%-16s %s, %0d errors", cur_test, (n == 0) ? "ok" : "FAIL", n);
  endtask

  task automatic test_magic_result();
    coproc_pkg::issue_resp_t resp;
    coproc_pkg::result_t     r;
    coproc_pkg::id_t         id;
    begin_test("test_opcode");
    id = next_id;
    next_id++;
    issue_insn(encode(coproc_pkg::opcode_test, coproc_pkg::rmcs, 5'd17), 32'h1, 32'h2, id,
               resp);
    check_bool("accept", 1'b1, resp.accept);
    check_bool("writeback", 1'b1, resp.writeback);
    check_bool("loadstore", 1'b0, resp.loadstore);
    send_commit(id, 1'b0);
    take_result(r);
    check_id("result id", id, r.id);
    check_word("result rd", 32'd17, coproc_pkg::word_t'(r.rd));
    check_word("result data", 32'hdead_beef, r.data);
    check_bool("result we", 1'b1, r.we);
    end_test();
  endtask

  task automatic test_kill_load();
    coproc_pkg::issue_resp_t resp;
    coproc_pkg::id_t         id;
    begin_test("kill_load");
    exec_insn(coproc_pkg::opcode_rmld, coproc_pkg::caslrm, 32'h200, 32'h80);
    id = next_id;
    next_id++;
    issue_insn(encode(coproc_pkg::opcode_rmld, coproc_pkg::rmcs, 5'd3), '0, '0, id, resp);
    send_commit(id, 1'b1);
    wait_idle();  // killed read drains first
    if (res_q.size() != 0) begin
      flag_failure("killed load returned a result");
    end
    if (wr_addr_q.size() != 0) begin
      flag_failure("killed load wrote to memory");
    end
    store_check(coproc_pkg::rmcs, 32'h200, window_word(32'h80));
    end_test();
  endtask

  task automatic test_back_pressure();
    begin_test("back_pressure");
    bp_on = 1'b1;
    run_config_load();
    run_store_selects();
    wait_idle();
    issue_valid = 1'b1;
    issue_req   = '{instr: 32'h0000_0033, rs1: '1, rs2: '1, id: next_id};  // plain add
    #1;
    check_bool("unknown accept", 1'b0, issue_resp.accept);
    @(negedge clk_i);
    issue_valid = 1'b0;
    @(negedge clk_i);
    check_bool("ready after unknown", 1'b1, issue_ready);
    if (res_q.size() != 0) begin
      flag_failure("unknown opcode produced a result");
    end
    bp_on = 1'b0;
    end_test();
  endtask

  initial begin
    seed         = 77227;
    bp_on        = 1'b0;
    errors       = 0;
    failing      = 0;
    tests_run    = 0;
    next_id      = '0;
    cur_test     = "reset";
    rst_ni       = 1'b0;
    issue_valid  = 1'b0;
    issue_req    = '0;
    commit_valid = 1'b0;
    commit       = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    begin_test("reset");
    check_bool("mem_valid after reset", 1'b0, mem_valid);
    check_bool("result_valid after reset", 1'b0, result_valid);
    check_bool("issue_ready after reset", 1'b1, issue_ready);
    end_test();
    test_magic_result();
    begin_test("config_load");
    run_config_load();
    end_test();
    begin_test("store_selects");
    run_store_selects();
    end_test();
    test_kill_load();
    test_back_pressure();
    $display("%0d tests run, %0d failing, %0d errors", tests_run, failing, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
coproc_pkg.sv
coproc_issue_stage.sv
coproc_stream_regs.sv
coproc_ctrl.sv
coproc_top.sv
coproc_tb.sv

// File: Makefile
# Verilator build and run of the coprocessor testbench

VERILATOR ?= verilator
TOP       ?= coproc_tb
FILELIST  ?= compile.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
